/* list.f */
+incdir+verilog
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/hazardUnit.sv
verilog/cpu.sv
tb/cpu_checker.sv
tb/cpuMonitor.sv
tb/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpuTb -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/VcpuTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
  exit 0
fi
exit 1

/* tb/cpuMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuMonitor import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  word_t   pc,
  input  logic    wbValid,
  input  regIdx_t wbReg,
  input  word_t   wbData,
  input  logic    hlt,
  input  int      testId,
  input  int      expLen,
  input  regIdx_t expRegs [64],
  input  word_t   expVals [64],
  output logic    done,
  output int      errCount
);

  int   idx;
  int   testErrs;
  logic resetQ;

  initial begin
    done     = 1'b0;
    errCount = 0;
    resetQ   = 1'b0;
  end

  task automatic noteError();
    errCount++;
    testErrs++;
  endtask

  always @(posedge clk) begin
    // State right after a reset edge
    if (resetQ) begin
      if (pc != '0) begin
        $display("[ERROR] pc after reset: expected %h actual %h", 16'h0000, pc);
        noteError();
      end
      if (wbValid || hlt) begin
        $display("Retirement or halt seen while in reset");
        noteError();
      end
    end
    resetQ = reset;
    if (reset) begin
      idx      = 0;
      testErrs = 0;
      done     = 1'b0;
    end else if (!done) begin
      if (wbValid) begin
        if (idx >= expLen) begin
          $display("Retirement of r%0d beyond the expected sequence", wbReg);
          noteError();
        end else begin
          if (wbReg != expRegs[idx]) begin
            $display("[ERROR] wbReg #%0d: expected %h actual %h", idx, expRegs[idx], wbReg);
            noteError();
          end
          if (wbData != expVals[idx]) begin
            $display("[ERROR] wbData #%0d: expected %h actual %h", idx, expVals[idx], wbData);
            noteError();
          end
          idx++;
        end
      end
      // Halt closes the test
      if (hlt) begin
        if (idx != expLen) begin
          $display("Halt with %0d expected writes still outstanding", expLen - idx);
          noteError();
        end
        $display("Test %0d %s, %0d writes checked", testId,
                 (testErrs == 0) ? "passed" : "failed", idx);
        done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb import cpuPkg::*; ;

  localparam int CycleLimit = 5 * 48 * 3 + 100;

  logic        clk = 1'b0;
  logic        reset;
  word_t       pc;
  word_t       instr;
  logic        wbValid;
  regIdx_t     wbReg;
  word_t       wbData;
  logic        hlt;
  logic        done;
  int          errCount;
  int          testId;
  int          expLen;
  int          cycles;
  int unsigned seed;
  word_t       prog [64];
  regIdx_t     expRegs [64];
  word_t       expVals [64];

  always #4 clk = ~clk;

  cpu uut (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .hlt(hlt)
  );

  cpuMonitor mon (
    .clk(clk), .reset(reset), .pc(pc), .wbValid(wbValid), .wbReg(wbReg),
    .wbData(wbData), .hlt(hlt), .testId(testId), .expLen(expLen),
    .expRegs(expRegs), .expVals(expVals), .done(done), .errCount(errCount)
  );

  // Instruction memory, HLT past the program
  assign instr = (pc[15:7] == '0) ? prog[pc[6:1]] : {`OP_HLT, 12'h000};

  always @(posedge clk) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int unsigned lcg(input int unsigned range);
    seed = seed * 32'd1103515245 + 32'd12345;
    return (seed >> 16) % range;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Program generation

  // Kind 0 ALU, 1 memory, 2 branches, 3 everything
  task automatic genProgram(input int kind);
    int unsigned r;
    int          maxOff;
    for (int i = 0; i < 64; i++) begin
      prog[i] = {`OP_HLT, 12'h000};
    end
    // Seed r1..r4
    for (int i = 0; i < 4; i++) begin
      prog[i] = {`OP_LLI, 4'(i + 1), 8'(lcg(256))};
    end
    for (int i = 4; i < 47; i++) begin
      r = lcg(16);
      if ((kind == 2 && r < 6) || (kind == 3 && r < 3)) begin
        // Forward only, at most onto the final HLT
        maxOff = 46 - i;
        if (maxOff > 4) begin
          maxOff = 4;
        end
        prog[i] = {`OP_B, 3'(lcg(8)), 9'(lcg(maxOff + 1))};
      end else if ((kind == 1 && r < 5) || (kind == 3 && r < 5)) begin
        prog[i] = {`OP_SW, 4'(lcg(8)), (lcg(4) == 0) ? 4'(lcg(8)) : 4'h0, 4'(lcg(16))};
      end else if ((kind == 1 && r < 10) || (kind == 3 && r < 7)) begin
        prog[i] = {`OP_LW, 4'(lcg(8)), (lcg(4) == 0) ? 4'(lcg(8)) : 4'h0, 4'(lcg(16))};
      end else if (r < 14) begin
        // Opcodes 0..5 are the ALU and shift ops
        prog[i] = {4'((kind == 2) ? lcg(4) : lcg(6)), 4'(lcg(8)), 4'(lcg(8)), 4'(lcg(8))};
      end else begin
        prog[i] = {`OP_LLI, 4'(lcg(8)), 8'(lcg(256))};
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // ISA model, in program order

  task automatic runModel();
    word_t      r [16];
    word_t      mem [256];
    logic       z;
    logic       v;
    logic       n;
    logic       wr;
    logic       taken;
    int         idx;
    word_t      w;
    word_t      res;
    word_t      addr;
    logic [3:0] fa;
    logic [3:0] fb;
    logic [3:0] fc;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
    z = 1'b0;
    v = 1'b0;
    n = 1'b0;
    idx = 0;
    expLen = 0;
    while (idx < 64 && prog[idx][15:12] != `OP_HLT) begin
      w = prog[idx];
      fa = w[11:8];
      fb = w[7:4];
      fc = w[3:0];
      addr = r[fb] + {12'h000, fc};
      wr = 1'b0;
      res = '0;
      idx++;
      case (w[15:12])
        `OP_ADD: begin
          res = r[fb] + r[fc];
          v = (r[fb][15] == r[fc][15]) && (res[15] != r[fb][15]);
          n = res[15];
          z = (res == '0);
          wr = 1'b1;
        end
        `OP_SUB: begin
          res = r[fb] - r[fc];
          v = (r[fb][15] != r[fc][15]) && (res[15] != r[fb][15]);
          n = res[15];
          z = (res == '0);
          wr = 1'b1;
        end
        `OP_AND, `OP_XOR, `OP_SLL, `OP_SRL: begin
          case (w[15:12])
            `OP_AND: res = r[fb] & r[fc];
            `OP_XOR: res = r[fb] ^ r[fc];
            `OP_SLL: res = r[fb] << fc;
            default: res = r[fb] >> fc;
          endcase
          z = (res == '0);
          wr = 1'b1;
        end
        `OP_LW: begin
          res = mem[addr[7:0]];
          wr = 1'b1;
        end
        `OP_SW: mem[addr[7:0]] = r[fa];
        `OP_LLI: begin
          res = {{8{w[7]}}, w[7:0]};
          wr = 1'b1;
        end
        default: begin
          case (w[11:9])
            `COND_NE: taken = !z;
            `COND_EQ: taken = z;
            `COND_GT: taken = !z && !n;
            `COND_LT: taken = n;
            `COND_GE: taken = z || !n;
            `COND_LE: taken = z || n;
            `COND_OV: taken = v;
            default:  taken = 1'b1;
          endcase
          // Index already past the branch
          if (taken) begin
            idx = idx + int'($signed(w[8:0]));
          end
        end
      endcase
      if (wr && fa != 4'h0) begin
        r[fa] = res;
        expRegs[expLen] = fa;
        expVals[expLen] = res;
        expLen++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing

  // New program loaded while the core sits in reset
  task automatic startProgram(input int kind);
    @(negedge clk);
    reset = 1'b1;
    genProgram(kind);
    runModel();
    repeat (5) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic runTest(input int kind);
    testId++;
    startProgram(kind);
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
    end
  endtask

  initial begin
    reset = 1'b1;
    cycles = 0;
    testId = 0;
    expLen = 0;
    seed = 30864;
    for (int i = 0; i < 64; i++) begin
      prog[i] = {`OP_HLT, 12'h000};
      expRegs[i] = '0;
      expVals[i] = '0;
    end
    runTest(0);
    runTest(1);
    runTest(2);
    runTest(3);
    // Abandon a program with stores partway, then a fresh mixed one
    startProgram(1);
    repeat (20) @(negedge clk);
    runTest(3);
    @(negedge clk);
    $display("%0d tests, %0d errors, %0d assertion failures",
             testId, errCount, uut.chk.failCount);
    if (errCount == 0 && uut.chk.failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpuPkg::*; (
  input logic    clk,
  input logic    reset,
  input word_t   pc,
  input logic    wbValid,
  input regIdx_t wbReg,
  input logic    hlt
);

  // Read by the testbench at the end of the run
  int failCount = 0;

  // Halfword aligned fetch
  pcEven: assert property (@(posedge clk) disable iff (reset) !pc[0])
    else begin
      $error("pc is odd");
      failCount++;
    end

  // R0 writes never retire
  noZeroReg: assert property (@(posedge clk) disable iff (reset) !(wbValid && (wbReg == '0)))
    else begin
      $error("retirement to register zero");
      failCount++;
    end

  // Sticky halt
  hltHolds: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
    else begin
      $error("hlt dropped without reset");
      failCount++;
    end

  quietAfterHlt: assert property (@(posedge clk) disable iff (reset) !(wbValid && hlt))
    else begin
      $error("retirement while halted");
      failCount++;
    end

endmodule

bind cpu cpu_checker chk (
  .clk(clk), .reset(reset), .pc(pc), .wbValid(wbValid), .wbReg(wbReg), .hlt(hlt)
);

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  output word_t   pc,
  input  word_t   instr,
  output logic    wbValid,
  output regIdx_t wbReg,
  output word_t   wbData,
  output logic    hlt
);

  // Hazard control
  logic    stall;
  logic    flush;
  logic    branchTaken;
  fwdSel_t fwdA;
  fwdSel_t fwdB;
  fwdSel_t storeSel;
  logic    haltSeen;
  logic    haltStop;

  // IF/ID
  logic    ifIdValid;
  word_t   ifIdInstr;
  word_t   ifIdPc;

  // Decode
  opcode_t idOpcode;
  regIdx_t idRd, idRs, idRt;
  word_t   idImm, idOffset, idRsData, idRtData;
  cond_t   idCond;
  logic    idRegWrite, idMemRead, idMemWrite, idUseRs, idUseRt, idIsHalt;

  // ID/EX
  logic    idExValid;
  opcode_t idExOpcode;
  regIdx_t idExRd, idExRs, idExRt;
  word_t   idExImm, idExOffset, idExPc, idExRsData, idExRtData;
  cond_t   idExCond;
  logic    idExRegWrite, idExMemRead, idExMemWrite, idExIsHalt;

  // Execute
  word_t   exOperandA, exOperandB, exResult, exTarget;

  // EX/MEM
  logic    exMemValid;
  regIdx_t exMemRd, exMemRt;
  word_t   exMemResult, exMemStoreData;
  logic    exMemRegWrite, exMemMemRead, exMemMemWrite, exMemIsHalt;

  // Memory stage
  word_t   dmem [1 << `DMEM_AW];
  word_t   memLoadData, memStoreData;

  // MEM/WB
  logic    memWbValid, memWbRegWrite, memWbMemRead;
  regIdx_t memWbRd;
  word_t   memWbResult, memWbLoadData;

  // Operand select shared by both ALU inputs and store data
  function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                   input word_t memVal, input word_t wbVal);
    case (sel)
      FWD_MEM: fwdMux = memVal;
      FWD_WB:  fwdMux = wbVal;
      default: fwdMux = regVal;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Fetch

  // Stop fetching as soon as HLT sits in decode
  assign haltStop = haltSeen || (ifIdValid && idIsHalt);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      haltSeen <= 1'b0;
    end else begin
      if (flush) begin
        pc <= exTarget;
      end else if (!stall && !haltStop) begin
        pc <= pc + 16'd2;
      end
      // A flushed HLT never counts
      if (ifIdValid && idIsHalt && !flush) begin
        haltSeen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ifIdValid <= 1'b0;
    end else if (!stall) begin
      ifIdValid <= !haltStop;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ifIdInstr <= instr;
      ifIdPc    <= pc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  instrDecoder decoder (
    .instr(ifIdInstr), .opcode(idOpcode), .rd(idRd), .rs(idRs), .rt(idRt),
    .imm(idImm), .cond(idCond), .branchOffset(idOffset),
    .regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
    .useRs(idUseRs), .useRt(idUseRt), .isHalt(idIsHalt)
  );

  regFile regs (
    .clk(clk), .reset(reset),
    .readIdxA(idRs), .readIdxB(idRt), .readDataA(idRsData), .readDataB(idRtData),
    .writeEn(memWbValid && memWbRegWrite), .writeIdx(memWbRd), .writeData(wbData)
  );

  hazardUnit hazard (
    .idRs(idRs), .idRt(idRt), .idUseRs(idUseRs), .idUseRt(idUseRt),
    .exValid(idExValid), .exMemRead(idExMemRead),
    .exRd(idExRd), .exRs(idExRs), .exRt(idExRt),
    .memValid(exMemValid), .memRegWrite(exMemRegWrite), .memRd(exMemRd),
    .wbValid(memWbValid), .wbRegWrite(memWbRegWrite), .wbRd(memWbRd),
    .branchTaken(branchTaken), .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
  );

  // Bubble into execute on stall or flush
  always_ff @(posedge clk) begin
    if (reset || flush || stall) begin
      idExValid <= 1'b0;
    end else begin
      idExValid <= ifIdValid;
    end
  end

  always_ff @(posedge clk) begin
    idExOpcode   <= idOpcode;
    idExRd       <= idRd;
    idExRs       <= idRs;
    idExRt       <= idRt;
    idExImm      <= idImm;
    idExOffset   <= idOffset;
    idExPc       <= ifIdPc;
    idExRsData   <= idRsData;
    idExRtData   <= idRtData;
    idExCond     <= idCond;
    idExRegWrite <= idRegWrite;
    idExMemRead  <= idMemRead;
    idExMemWrite <= idMemWrite;
    idExIsHalt   <= idIsHalt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Execute

  assign exOperandA = fwdMux(fwdA, idExRsData, exMemResult, wbData);
  assign exOperandB = fwdMux(fwdB, idExRtData, exMemResult, wbData);
  // Branch address plus 2 plus offset in halfwords
  assign exTarget   = idExPc + 16'd2 + {idExOffset[14:0], 1'b0};

  executeUnit alu (
    .clk(clk), .reset(reset), .valid(idExValid), .opcode(idExOpcode),
    .operandA(exOperandA), .operandB(exOperandB), .imm(idExImm), .cond(idExCond),
    .result(exResult), .branchTaken(branchTaken)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      exMemValid <= 1'b0;
    end else begin
      exMemValid <= idExValid;
    end
  end

  always_ff @(posedge clk) begin
    exMemRd        <= idExRd;
    exMemRt        <= idExRt;
    exMemResult    <= exResult;
    exMemStoreData <= exOperandB;
    exMemRegWrite  <= idExRegWrite;
    exMemMemRead   <= idExMemRead;
    exMemMemWrite  <= idExMemWrite;
    exMemIsHalt    <= idExIsHalt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory

  // Store data refreshed from writeback
  assign storeSel = (memWbValid && memWbRegWrite && (memWbRd != '0) && (memWbRd == exMemRt)) ?
                    FWD_WB : FWD_REG;
  assign memStoreData = fwdMux(storeSel, exMemStoreData, exMemResult, wbData);
  // Word addressed, upper address bits ignored
  assign memLoadData  = dmem[exMemResult[`DMEM_AW-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < (1 << `DMEM_AW); i++) begin
        dmem[i] <= '0;
      end
    end else if (exMemValid && exMemMemWrite) begin
      dmem[exMemResult[`DMEM_AW-1:0]] <= memStoreData;
    end
  end

  // hlt goes high with HLT in writeback and sticks
  always_ff @(posedge clk) begin
    if (reset) begin
      memWbValid <= 1'b0;
      hlt        <= 1'b0;
    end else begin
      memWbValid <= exMemValid;
      if (exMemValid && exMemIsHalt) begin
        hlt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    memWbRegWrite <= exMemRegWrite;
    memWbMemRead  <= exMemMemRead;
    memWbRd       <= exMemRd;
    memWbResult   <= exMemResult;
    memWbLoadData <= memLoadData;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writeback

  assign wbData  = memWbMemRead ? memWbLoadData : memWbResult;
  assign wbReg   = memWbRd;
  // Retire only real register writes
  assign wbValid = memWbValid && memWbRegWrite && (memWbRd != '0);

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  // Data or address word
  typedef logic [15:0] word_t;
  // Register number
  typedef logic [3:0] regIdx_t;
  typedef logic [3:0] opcode_t;
  typedef logic [2:0] cond_t;
  // Z V N, Z in the MSB
  typedef logic [2:0] flags_t;

  // Execute operand source
  typedef logic [1:0] fwdSel_t;

  localparam fwdSel_t FWD_REG = 2'd0;
  localparam fwdSel_t FWD_MEM = 2'd1;
  localparam fwdSel_t FWD_WB  = 2'd2;

endpackage

`default_nettype wire

/* verilog/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Opcodes, instr[15:12]
`define OP_ADD 4'b0000
`define OP_SUB 4'b0001
`define OP_AND 4'b0010
`define OP_XOR 4'b0011
`define OP_SLL 4'b0100
`define OP_SRL 4'b0101
`define OP_LW  4'b1000
`define OP_SW  4'b1001
`define OP_LLI 4'b1010
`define OP_B   4'b1100
`define OP_HLT 4'b1111

// Branch conditions, instr[11:9]
`define COND_NE 3'b000
`define COND_EQ 3'b001
`define COND_GT 3'b010
`define COND_LT 3'b011
`define COND_GE 3'b100
`define COND_LE 3'b101
`define COND_OV 3'b110
`define COND_AL 3'b111

// Data memory word address bits
`define DMEM_AW 8

`endif

/* verilog/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module executeUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    valid,
  input  opcode_t opcode,
  input  word_t   operandA,
  input  word_t   operandB,
  input  word_t   imm,
  input  cond_t   cond,
  output word_t   result,
  output logic    branchTaken
);

  flags_t flags;
  word_t  sum;
  word_t  diff;
  logic   ovfl;
  logic   setAll;
  logic   setZero;
  logic   condHolds;
  logic   zFlag;
  logic   vFlag;
  logic   nFlag;

  assign sum  = operandA + operandB;
  assign diff = operandA - operandB;

  // Signed overflow, sign of B flipped for SUB
  assign ovfl = (opcode == `OP_SUB) ?
                ((operandA[15] != operandB[15]) && (diff[15] != operandA[15])) :
                ((operandA[15] == operandB[15]) && (sum[15] != operandA[15]));

  always_comb begin
    case (opcode)
      `OP_ADD:        result = sum;
      `OP_SUB:        result = diff;
      `OP_AND:        result = operandA & operandB;
      `OP_XOR:        result = operandA ^ operandB;
      `OP_SLL:        result = operandA << imm[3:0];
      `OP_SRL:        result = operandA >> imm[3:0];
      // Effective address
      `OP_LW, `OP_SW: result = operandA + imm;
      `OP_LLI:        result = imm;
      default:        result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flag register

  assign setAll  = valid && ((opcode == `OP_ADD) || (opcode == `OP_SUB));
  assign setZero = valid && ((opcode == `OP_AND) || (opcode == `OP_XOR) ||
                             (opcode == `OP_SLL) || (opcode == `OP_SRL));

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (setAll) begin
      flags <= {(result == '0), ovfl, result[15]};
    end else if (setZero) begin
      // Logic and shifts touch Z only
      flags[2] <= (result == '0);
    end
  end

  assign zFlag = flags[2];
  assign vFlag = flags[1];
  assign nFlag = flags[0];

  ////////////////////////////////////////////////////////////////////////////
  // Branch condition, stored flags only

  always_comb begin
    case (cond)
      `COND_NE: condHolds = !zFlag;
      `COND_EQ: condHolds = zFlag;
      `COND_GT: condHolds = !zFlag && !nFlag;
      `COND_LT: condHolds = nFlag;
      `COND_GE: condHolds = zFlag || !nFlag;
      `COND_LE: condHolds = zFlag || nFlag;
      `COND_OV: condHolds = vFlag;
      default:  condHolds = 1'b1;
    endcase
  end

  assign branchTaken = valid && (opcode == `OP_B) && condHolds;

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
  input  regIdx_t idRs,
  input  regIdx_t idRt,
  input  logic    idUseRs,
  input  logic    idUseRt,
  input  logic    exValid,
  input  logic    exMemRead,
  input  regIdx_t exRd,
  input  regIdx_t exRs,
  input  regIdx_t exRt,
  input  logic    memValid,
  input  logic    memRegWrite,
  input  regIdx_t memRd,
  input  logic    wbValid,
  input  logic    wbRegWrite,
  input  regIdx_t wbRd,
  input  logic    branchTaken,
  output fwdSel_t fwdA,
  output fwdSel_t fwdB,
  output logic    stall,
  output logic    flush
);

  logic loadUse;

  // Youngest producer wins, R0 never forwarded
  function automatic fwdSel_t pickSource(input regIdx_t src);
    pickSource = FWD_REG;
    if (wbValid && wbRegWrite && (wbRd != '0) && (wbRd == src)) begin
      pickSource = FWD_WB;
    end
    if (memValid && memRegWrite && (memRd != '0) && (memRd == src)) begin
      pickSource = FWD_MEM;
    end
  endfunction

  always_comb begin
    fwdA = pickSource(exRs);
    fwdB = pickSource(exRt);
  end

  // Load result not ready until writeback
  assign loadUse = exValid && exMemRead && (exRd != '0) &&
                   ((idUseRs && (idRs == exRd)) || (idUseRt && (idRt == exRd)));

  // Flush squashes decode anyway
  assign stall = loadUse && !branchTaken;
  assign flush = branchTaken;

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module instrDecoder import cpuPkg::*; (
  input  word_t   instr,
  output opcode_t opcode,
  output regIdx_t rd,
  output regIdx_t rs,
  output regIdx_t rt,
  output word_t   imm,
  output cond_t   cond,
  output word_t   branchOffset,
  output logic    regWrite,
  output logic    memRead,
  output logic    memWrite,
  output logic    useRs,
  output logic    useRt,
  output logic    isHalt
);

  logic isRegOp;
  logic isShift;
  logic isLoad;
  logic isStore;

  // Field split
  assign opcode = instr[15:12];
  assign rd     = instr[11:8];
  assign rs     = instr[7:4];
  // SW carries its data register in the rd slot
  assign rt     = isStore ? instr[11:8] : instr[3:0];
  assign cond   = instr[11:9];

  // LLI gets a signed byte, the rest an unsigned nibble
  assign imm = (opcode == `OP_LLI) ? {{8{instr[7]}}, instr[7:0]} : {12'h000, instr[3:0]};
  // Offset in halfwords, scaled in execute
  assign branchOffset = {{7{instr[8]}}, instr[8:0]};

  // Instruction classes
  assign isRegOp = (opcode == `OP_ADD) || (opcode == `OP_SUB) ||
                   (opcode == `OP_AND) || (opcode == `OP_XOR);
  assign isShift = (opcode == `OP_SLL) || (opcode == `OP_SRL);
  assign isLoad  = (opcode == `OP_LW);
  assign isStore = (opcode == `OP_SW);

  // Control bits
  assign regWrite = isRegOp || isShift || isLoad || (opcode == `OP_LLI);
  assign memRead  = isLoad;
  assign memWrite = isStore;
  assign isHalt   = (opcode == `OP_HLT);

  // Source usage for hazard checks
  assign useRs = isRegOp || isShift || isLoad || isStore;
  assign useRt = isRegOp || isStore;

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t readIdxA,
  input  regIdx_t readIdxB,
  output word_t   readDataA,
  output word_t   readDataB,
  input  logic    writeEn,
  input  regIdx_t writeIdx,
  input  word_t   writeData
);

  word_t regs [16];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeIdx != '0)) begin
      regs[writeIdx] <= writeData;
    end
  end

  // R0 hardwired, then writeback bypass
  assign readDataA = (readIdxA == '0) ? '0 :
                     (writeEn && (writeIdx == readIdxA)) ? writeData : regs[readIdxA];
  assign readDataB = (readIdxB == '0) ? '0 :
                     (writeEn && (writeIdx == readIdxB)) ? writeData : regs[readIdxB];

endmodule

`default_nettype wire
